// ==== hdl/axi_bus_pkg.sv ====
// AXI bus definitions
package axi_bus_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  // One strobe bit per byte lane
  localparam int STRB_W = DATA_W / 8;

  // ------------------------------------------------------------
  // Response codes
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

endpackage

// ==== hdl/sram_cfg_pkg.sv ====
// SRAM geometry
package sram_cfg_pkg;

  // Word count and index width
  localparam int unsigned MEM_DEPTH = 256;
  localparam int IDX_W = $clog2(MEM_DEPTH);

  // Byte select bits inside a 64-bit word
  localparam int BYTE_OFS_W = 3;

  // First byte address past the array
  localparam int unsigned MEM_BYTES = MEM_DEPTH << BYTE_OFS_W;

endpackage

// ==== hdl/axi4_lite_beat_if.sv ====
// Single-beat AXI4 link
interface axi4_lite_beat_if;

  // Write address
  logic [axi_bus_pkg::ADDR_W-1:0] aw_addr;
  logic                           aw_valid;
  logic                           aw_ready;

  // Write data
  logic [axi_bus_pkg::DATA_W-1:0] w_data;
  logic [axi_bus_pkg::STRB_W-1:0] w_strb;
  logic                           w_last;
  logic                           w_valid;
  logic                           w_ready;

  // Write response
  axi_bus_pkg::axi_resp_e         b_resp;
  logic                           b_valid;
  logic                           b_ready;

  // Read address
  logic [axi_bus_pkg::ADDR_W-1:0] ar_addr;
  logic                           ar_valid;
  logic                           ar_ready;

  // Read data
  logic [axi_bus_pkg::DATA_W-1:0] r_data;
  axi_bus_pkg::axi_resp_e         r_resp;
  logic                           r_last;
  logic                           r_valid;
  logic                           r_ready;

  modport master (
    output aw_addr, aw_valid, input aw_ready,
    output w_data, w_strb, w_last, w_valid, input w_ready,
    input b_resp, b_valid, output b_ready,
    output ar_addr, ar_valid, input ar_ready,
    input r_data, r_resp, r_last, r_valid, output r_ready
  );

  modport slave (
    input aw_addr, aw_valid, output aw_ready,
    input w_data, w_strb, w_last, w_valid, output w_ready,
    output b_resp, b_valid, input b_ready,
    input ar_addr, ar_valid, output ar_ready,
    output r_data, r_resp, r_last, r_valid, input r_ready
  );

endinterface

// ==== hdl/sram_array.sv ====
// Byte-strobed SRAM
module sram_array (
  input  logic                           i_aclk,
  input  logic                           i_en,
  input  logic [axi_bus_pkg::STRB_W-1:0] i_we,
  input  logic [sram_cfg_pkg::IDX_W-1:0] i_idx,
  input  logic [axi_bus_pkg::DATA_W-1:0] i_wdata,
  output logic [axi_bus_pkg::DATA_W-1:0] o_rdata
);

  logic [axi_bus_pkg::DATA_W-1:0] mem [sram_cfg_pkg::MEM_DEPTH];

  // Read-first, output registered
  always_ff @(posedge i_aclk) begin
    if (i_en) begin
      for (int b = 0; b < axi_bus_pkg::STRB_W; b++) begin
        if (i_we[b]) begin
          mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
      o_rdata <= mem[i_idx];
    end
  end

endmodule

// ==== hdl/axi4_sram_slave.sv ====
// AXI4 SRAM slave
module axi4_sram_slave (
  input  logic                               i_aclk,
  input  logic                               i_arst_n,
  axi4_lite_beat_if.slave                    s_axi,
  output logic                               o_mem_en,
  output logic [axi_bus_pkg::STRB_W-1:0]     o_mem_we,
  output logic [sram_cfg_pkg::IDX_W-1:0]     o_mem_idx,
  output logic [axi_bus_pkg::DATA_W-1:0]     o_mem_wdata,
  input  logic [axi_bus_pkg::DATA_W-1:0]     i_mem_rdata
);

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  rd_state_e                          rd_state_q;
  wr_state_e                          wr_state_q;
  logic                               ar_fire;
  logic                               r_fire;
  logic                               aw_fire;
  logic                               w_fire;
  logic                               b_fire;
  logic                               ar_oor;
  logic                               aw_oor;
  logic                               rd_pend_q;
  logic                               r_valid_q;
  logic                               rd_err_q;
  logic                               wr_err_q;
  logic [sram_cfg_pkg::IDX_W-1:0]     aw_idx_q;
  logic [axi_bus_pkg::DATA_W-1:0]     r_data_q;

  assign ar_fire = s_axi.ar_valid && s_axi.ar_ready;
  assign r_fire  = s_axi.r_valid && s_axi.r_ready;
  assign aw_fire = s_axi.aw_valid && s_axi.aw_ready;
  assign w_fire  = s_axi.w_valid && s_axi.w_ready;
  assign b_fire  = s_axi.b_valid && s_axi.b_ready;

  // Address decode
  assign ar_oor = (s_axi.ar_addr >= sram_cfg_pkg::MEM_BYTES);
  assign aw_oor = (s_axi.aw_addr >= sram_cfg_pkg::MEM_BYTES);

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state_q <= RD_IDLE;
      rd_pend_q  <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      rd_pend_q <= ar_fire;
      if (rd_pend_q) r_valid_q <= 1'b1;
      else if (r_fire) r_valid_q <= 1'b0;
      case (rd_state_q)
        RD_IDLE: if (ar_fire) rd_state_q <= RD_DATA;
        RD_DATA: if (r_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) rd_err_q <= ar_oor;
    // SRAM output lands one cycle after the AR beat
    if (rd_pend_q) r_data_q <= rd_err_q ? '0 : i_mem_rdata;
  end

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (aw_fire) wr_state_q <= WR_DATA;
        WR_DATA: if (w_fire) wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_idx_q <= s_axi.aw_addr[sram_cfg_pkg::BYTE_OFS_W +: sram_cfg_pkg::IDX_W];
      wr_err_q <= aw_oor;
    end
  end

  // Single SRAM port, reads are held off while a write beat is due
  assign s_axi.ar_ready = (rd_state_q == RD_IDLE) && (wr_state_q != WR_DATA);
  assign s_axi.r_valid  = r_valid_q;
  assign s_axi.r_data   = r_data_q;
  assign s_axi.r_resp   = rd_err_q ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;
  assign s_axi.r_last   = 1'b1;
  assign s_axi.aw_ready = (wr_state_q == WR_IDLE);
  assign s_axi.w_ready  = (wr_state_q == WR_DATA);
  assign s_axi.b_valid  = (wr_state_q == WR_RESP);
  assign s_axi.b_resp   = wr_err_q ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;

  // SRAM port
  assign o_mem_en    = (ar_fire && !ar_oor) || (w_fire && !wr_err_q);
  assign o_mem_we    = w_fire ? s_axi.w_strb : '0;
  assign o_mem_wdata = s_axi.w_data;
  assign o_mem_idx   = ar_fire ? s_axi.ar_addr[sram_cfg_pkg::BYTE_OFS_W +: sram_cfg_pkg::IDX_W]
                               : aw_idx_q;

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    s_axi.r_valid && !s_axi.r_ready |=> s_axi.r_valid && $stable(s_axi.r_data));

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    s_axi.b_valid && !s_axi.b_ready |=> s_axi.b_valid && $stable(s_axi.b_resp));

  a_aw_w_excl: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    !(s_axi.aw_ready && s_axi.w_ready));

  // Single-beat bursts only
  a_w_last: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    w_fire |-> s_axi.w_last);

endmodule

// ==== hdl/lsu_axi_bridge.sv ====
// Core request to AXI bridge
module lsu_axi_bridge (
  input  logic                           i_aclk,
  input  logic                           i_arst_n,
  input  logic                           i_req,
  input  logic                           i_we,
  input  logic [axi_bus_pkg::ADDR_W-1:0] i_addr,
  input  logic [axi_bus_pkg::DATA_W-1:0] i_wdata,
  input  logic [axi_bus_pkg::STRB_W-1:0] i_wstrb,
  output logic                           o_ack,
  output logic [axi_bus_pkg::DATA_W-1:0] o_rdata,
  output logic                           o_err,
  axi4_lite_beat_if.master               m_axi
);

  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_REQ,
    WR_RESP,
    ACK_HOLD
  } bridge_state_e;

  bridge_state_e                  state_q;
  logic                           aw_pend_q;
  logic                           w_pend_q;
  logic [axi_bus_pkg::ADDR_W-1:0] addr_q;
  logic [axi_bus_pkg::DATA_W-1:0] wdata_q;
  logic [axi_bus_pkg::STRB_W-1:0] wstrb_q;
  logic                           ar_fire;
  logic                           r_fire;
  logic                           aw_fire;
  logic                           w_fire;
  logic                           b_fire;

  assign ar_fire = m_axi.ar_valid && m_axi.ar_ready;
  assign r_fire  = m_axi.r_valid && m_axi.r_ready;
  assign aw_fire = m_axi.aw_valid && m_axi.aw_ready;
  assign w_fire  = m_axi.w_valid && m_axi.w_ready;
  assign b_fire  = m_axi.b_valid && m_axi.b_ready;

  // ------------------------------------------------------------
  // Request FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_req && i_we) begin
            state_q   <= WR_REQ;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
          end else if (i_req) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: if (ar_fire) state_q <= RD_DATA;
        RD_DATA: if (r_fire && m_axi.r_last) state_q <= ACK_HOLD;
        WR_REQ: begin
          // AW and W may complete on different edges
          if (aw_fire) aw_pend_q <= 1'b0;
          if (w_fire) w_pend_q <= 1'b0;
          if ((aw_fire || !aw_pend_q) && (w_fire || !w_pend_q)) state_q <= WR_RESP;
        end
        WR_RESP: if (b_fire) state_q <= ACK_HOLD;
        ACK_HOLD: if (!i_req) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request payload, taken when a new access starts
  always_ff @(posedge i_aclk) begin
    if (state_q == IDLE && i_req) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
      wstrb_q <= i_wstrb;
    end
  end

  // Response capture
  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      o_rdata <= m_axi.r_data;
      o_err   <= (m_axi.r_resp == axi_bus_pkg::RESP_SLVERR);
    end else if (b_fire) begin
      o_err <= (m_axi.b_resp == axi_bus_pkg::RESP_SLVERR);
    end
  end

  assign m_axi.ar_addr  = addr_q;
  assign m_axi.ar_valid = (state_q == RD_ADDR);
  assign m_axi.r_ready  = (state_q == RD_DATA);
  assign m_axi.aw_addr  = addr_q;
  assign m_axi.aw_valid = aw_pend_q;
  assign m_axi.w_data   = wdata_q;
  assign m_axi.w_strb   = wstrb_q;
  assign m_axi.w_last   = 1'b1;
  assign m_axi.w_valid  = w_pend_q;
  assign m_axi.b_ready  = (state_q == WR_RESP);
  assign o_ack          = (state_q == ACK_HOLD);

  // Four-phase rule seen from the core side
  a_ack_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_ack && i_req |=> o_ack);

endmodule

// ==== hdl/axi_sram_top.sv ====
// AXI SRAM subsystem top
module axi_sram_top (
  input  logic                           i_aclk,
  input  logic                           i_arst_n,
  input  logic                           i_req,
  input  logic                           i_we,
  input  logic [axi_bus_pkg::ADDR_W-1:0] i_addr,
  input  logic [axi_bus_pkg::DATA_W-1:0] i_wdata,
  input  logic [axi_bus_pkg::STRB_W-1:0] i_wstrb,
  output logic                           o_ack,
  output logic [axi_bus_pkg::DATA_W-1:0] o_rdata,
  output logic                           o_err
);

  logic                           mem_en;
  logic [axi_bus_pkg::STRB_W-1:0] mem_we;
  logic [sram_cfg_pkg::IDX_W-1:0] mem_idx;
  logic [axi_bus_pkg::DATA_W-1:0] mem_wdata;
  logic [axi_bus_pkg::DATA_W-1:0] mem_rdata;

  axi4_lite_beat_if u_axi ();

  lsu_axi_bridge u_bridge (
    .i_aclk   (i_aclk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_we     (i_we),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_wstrb  (i_wstrb),
    .o_ack    (o_ack),
    .o_rdata  (o_rdata),
    .o_err    (o_err),
    .m_axi    (u_axi.master)
  );

  axi4_sram_slave u_slave (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .s_axi       (u_axi.slave),
    .o_mem_en    (mem_en),
    .o_mem_we    (mem_we),
    .o_mem_idx   (mem_idx),
    .o_mem_wdata (mem_wdata),
    .i_mem_rdata (mem_rdata)
  );

  sram_array u_sram (
    .i_aclk  (i_aclk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_idx   (mem_idx),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// ==== testbench/tb_axi_sram_top.sv ====
// AXI SRAM subsystem testbench
module tb_axi_sram_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W = axi_bus_pkg::ADDR_W;
  localparam int DATA_W = axi_bus_pkg::DATA_W;
  localparam int STRB_W = axi_bus_pkg::STRB_W;
  localparam int OFS_W  = sram_cfg_pkg::BYTE_OFS_W;
  localparam int BIDX_W = sram_cfg_pkg::IDX_W + OFS_W;

  localparam logic [ADDR_W-1:0] OOR_BASE  = sram_cfg_pkg::MEM_BYTES;
  // Word-aligned in-range address bits
  localparam logic [ADDR_W-1:0] ADDR_MASK = sram_cfg_pkg::MEM_BYTES - 8;
  localparam logic [STRB_W-1:0] STRB_PAT [4] = '{8'h01, 8'hF0, 8'h5A, 8'h80};

  localparam int FILL_N    = sram_cfg_pkg::MEM_DEPTH;
  localparam int FULL_N    = 8;
  localparam int STRB_N    = 8;
  localparam int OOR_N     = 7;
  localparam int RAND_N    = 40;
  localparam int TOTAL_ACC = FILL_N + FULL_N + STRB_N + OOR_N + RAND_N;

  logic              aclk = 1'b0;
  logic              arst_n;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              ack;
  logic [DATA_W-1:0] rdata;
  logic              err;

  // Expected response of the access in flight
  string             test_name   = "reset";
  logic [DATA_W-1:0] exp_rdata   = '0;
  logic              exp_err     = 1'b0;
  logic              exp_is_read = 1'b0;
  int                seed        = 58;

  logic [7:0] model_mem [sram_cfg_pkg::MEM_BYTES];

  always #5 aclk = ~aclk;

  axi_sram_top i_axi_sram_top (
    .i_aclk   (aclk),
    .i_arst_n (arst_n),
    .i_req    (req),
    .i_we     (we),
    .i_addr   (addr),
    .i_wdata  (wdata),
    .i_wstrb  (wstrb),
    .o_ack    (ack),
    .o_rdata  (rdata),
    .o_err    (err)
  );

  // ------------------------------------------------------------
  // Reference memory model
  // ------------------------------------------------------------
  function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] w;
    for (int b = 0; b < STRB_W; b++) begin
      w[b*8 +: 8] = model_mem[{a[BIDX_W-1:OFS_W], OFS_W'(b)}];
    end
    return w;
  endfunction

  function automatic void model_write(input logic [ADDR_W-1:0] a,
                                      input logic [DATA_W-1:0] d,
                                      input logic [STRB_W-1:0] s);
    for (int b = 0; b < STRB_W; b++) begin
      if (s[b]) begin
        model_mem[{a[BIDX_W-1:OFS_W], OFS_W'(b)}] = d[b*8 +: 8];
      end
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string field, input logic [DATA_W-1:0] expv,
                                 input logic [DATA_W-1:0] actv);
    abort_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, field, expv, actv));
  endtask

  // One four-phase core access
  task automatic run_access(input logic w, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
    logic oor;
    oor = (a >= sram_cfg_pkg::MEM_BYTES);
    @(posedge aclk);
    exp_err     = oor;
    exp_is_read = !w;
    // Reads past the array come back as zero
    exp_rdata   = (w || oor) ? '0 : model_word(a);
    req   <= 1'b1;
    we    <= w;
    addr  <= a;
    wdata <= d;
    wstrb <= s;
    do begin
      @(posedge aclk);
    end while (!ack);
    req <= 1'b0;
    do begin
      @(posedge aclk);
    end while (ack);
    if (w && !oor) model_write(a, d, s);
  endtask

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_reset_ack: assert property (@(posedge aclk) $rose(arst_n) |-> !ack)
    else abort_run("o_ack was high when reset was released");

  a_ack_rise: assert property (@(posedge aclk) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
    else abort_run("o_ack rose without a pending request");

  a_ack_fall: assert property (@(posedge aclk) disable iff (!arst_n)
    $fell(ack) |-> !$past(req))
    else abort_run("o_ack fell while i_req was still high");

  a_err: assert property (@(posedge aclk) disable iff (!arst_n)
    $rose(ack) |-> err == exp_err)
    else report_mismatch("o_err", DATA_W'(exp_err), DATA_W'(err));

  a_rdata: assert property (@(posedge aclk) disable iff (!arst_n)
    $rose(ack) && exp_is_read |-> rdata == exp_rdata)
    else report_mismatch("o_rdata", exp_rdata, rdata);

  // Watchdog of ten cycles per access plus margin
  initial begin
    #((TOTAL_ACC * 10 + 100) * 10);
    abort_run("Timeout: the DUT stopped answering requests");
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic [31:0]       r;
    arst_n = 1'b0;
    req    = 1'b0;
    we     = 1'b0;
    addr   = '0;
    wdata  = '0;
    wstrb  = '0;
    repeat (2) @(posedge aclk);
    arst_n <= 1'b1;

    // Every word gets a known value first
    test_name = "fill";
    for (int i = 0; i < FILL_N; i++) begin
      a = ADDR_W'(i << OFS_W);
      run_access(1'b1, a, {a, ~a}, '1);
    end

    test_name = "full_word";
    for (int i = 0; i < FULL_N / 2; i++) begin
      a = $random(seed) & ADDR_MASK;
      d = {$random(seed), $random(seed)};
      run_access(1'b1, a, d, '1);
      run_access(1'b0, a, '0, '0);
    end

    test_name = "byte_strobe";
    for (int i = 0; i < STRB_N / 2; i++) begin
      a = $random(seed) & ADDR_MASK;
      d = {$random(seed), $random(seed)};
      run_access(1'b1, a, d, STRB_PAT[i]);
      run_access(1'b0, a, '0, '0);
    end

    test_name = "oor_read";
    run_access(1'b0, OOR_BASE, '0, '0);
    run_access(1'b0, OOR_BASE + 32'h100, '0, '0);
    run_access(1'b0, 32'hFFFF_FFF8, '0, '0);
    for (int i = 0; i < 2; i++) begin
      a = (i == 0) ? 32'h10 : 32'h7F8;
      test_name = "oor_write";
      run_access(1'b1, OOR_BASE + a, {$random(seed), $random(seed)}, '1);
      test_name = "oor_alias";
      run_access(1'b0, a, '0, '0);
    end

    test_name = "random";
    for (int i = 0; i < RAND_N; i++) begin
      r = $random(seed);
      d = {$random(seed), $random(seed)};
      run_access(r[0], r & ADDR_MASK, d, r[23:16]);
    end

    @(posedge aclk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== axi_sram_top.f ====
hdl/axi_bus_pkg.sv
hdl/sram_cfg_pkg.sv
hdl/axi4_lite_beat_if.sv
hdl/sram_array.sv
hdl/axi4_sram_slave.sv
hdl/lsu_axi_bridge.sv
hdl/axi_sram_top.sv
testbench/tb_axi_sram_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_axi_sram_top -f axi_sram_top.f &&
  ./obj_dir/Vtb_axi_sram_top | tee /dev/stderr | grep "STATUS: PASS" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
